// ==== design/arch_rat.sv ====
module arch_rat #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic clk,
  input  logic rst_n,

  // Retiring slots from the commit queue
  input  logic [DECODE_WIDTH-1:0]                        ret_valid_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] ret_dest_i,
  input  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            ret_preg_i,

  output logic [rename_pkg::ARCH_REG_NUM-1:0][PREG_W-1:0] arch_map_o
);

  import rename_pkg::*;

  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] rat_q;
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] rat_n;
  logic [DECODE_WIDTH-1:0]             wen;

  always_comb begin
    // WAW inside the group, a later valid slot on the same register wins
    wen = ret_valid_i;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      for (int j = i + 1; j < DECODE_WIDTH; j++) begin
        wen[i] = wen[i] & ~(ret_valid_i[j] & (ret_dest_i[i] == ret_dest_i[j]));
      end
    end
    rat_n = rat_q;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      if (wen[i]) begin
        rat_n[ret_dest_i[i]] = ret_preg_i[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        rat_q[r] <= PREG_W'(r);
      end
    end else begin
      rat_q <= rat_n;
    end
  end

  // Committed state only
  assign arch_map_o = rat_q;

endmodule : arch_rat

// ==== design/commit_queue.sv ====
module commit_queue #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  parameter int QUEUE_DEPTH  = 16,
  localparam int PREG_W      = $clog2(PHY_REG_NUM),
  localparam int PTR_W       = $clog2(QUEUE_DEPTH),
  localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1)
) (
  input  logic clk,
  input  logic rst_n,

  input  logic rename_en_i,
  input  logic retire_en_i,
  input  logic flush_en_i,

  // Number of entries to pop, 0 to DECODE_WIDTH
  input  logic [$clog2(DECODE_WIDTH + 1)-1:0] retire_cnt_i,

  // Renamed group to log
  input  logic [DECODE_WIDTH-1:0]                        dest_valid_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] dest_i,
  input  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            pdst_i,
  input  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            old_pdst_i,

  output logic                                           space_ok_o,
  output logic [DECODE_WIDTH-1:0]                        ret_valid_o,
  output logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] ret_dest_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            ret_preg_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            ret_old_preg_o
);

  import rename_pkg::*;

  // Entry storage
  logic [QUEUE_DEPTH-1:0]             q_valid;
  logic [QUEUE_DEPTH-1:0][AREG_W-1:0] q_dest;
  logic [QUEUE_DEPTH-1:0][PREG_W-1:0] q_preg;
  logic [QUEUE_DEPTH-1:0][PREG_W-1:0] q_old;

  // Oldest entry, next free entry, occupancy
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  // Circular increment, off never exceeds the depth
  function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr,
                                              input int unsigned off);
    int unsigned sum;
    sum = ptr + off;
    if (sum >= QUEUE_DEPTH) begin
      sum = sum - QUEUE_DEPTH;
    end
    return PTR_W'(sum);
  endfunction

  // Room for a full group
  assign space_ok_o = (count_q <= CNT_W'(QUEUE_DEPTH - DECODE_WIDTH));

  // ==================================================
  // Retire slots, live only in the retire_en cycle
  // ==================================================
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      ret_valid_o[i]    = retire_en_i && (i < int'(retire_cnt_i)) &&
                          q_valid[ptr_add(head_q, i)];
      ret_dest_o[i]     = q_dest[ptr_add(head_q, i)];
      ret_preg_o[i]     = q_preg[ptr_add(head_q, i)];
      ret_old_preg_o[i] = q_old[ptr_add(head_q, i)];
    end
  end

  // Entry payload
  always_ff @(posedge clk) begin
    if (rename_en_i) begin
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        q_valid[ptr_add(tail_q, i)] <= dest_valid_i[i];
        q_dest[ptr_add(tail_q, i)]  <= dest_i[i];
        q_preg[ptr_add(tail_q, i)]  <= pdst_i[i];
        q_old[ptr_add(tail_q, i)]   <= old_pdst_i[i];
      end
    end
  end

  // Pointers and count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (flush_en_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else if (rename_en_i) begin
      tail_q  <= ptr_add(tail_q, DECODE_WIDTH);
      count_q <= count_q + CNT_W'(DECODE_WIDTH);
    end else if (retire_en_i) begin
      head_q  <= ptr_add(head_q, retire_cnt_i);
      count_q <= count_q - CNT_W'(retire_cnt_i);
    end
  end

endmodule : commit_queue

// ==== design/free_list.sv ====
module free_list #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic clk,
  input  logic rst_n,

  input  logic rename_en_i,
  input  logic flush_en_i,

  // Slots that need a new register
  input  logic [DECODE_WIDTH-1:0] dest_valid_i,

  // Displaced registers coming back on retire
  input  logic [DECODE_WIDTH-1:0]             ret_valid_i,
  input  logic [DECODE_WIDTH-1:0][PREG_W-1:0] ret_old_preg_i,

  // Committed map for the flush rebuild
  input  logic [rename_pkg::ARCH_REG_NUM-1:0][PREG_W-1:0] arch_map_i,

  output logic [DECODE_WIDTH-1:0][PREG_W-1:0] alloc_preg_o,
  output logic                                alloc_ok_o
);

  import rename_pkg::*;

  // One bit per physical register, set when free
  logic [PHY_REG_NUM-1:0] free_q;
  logic [PHY_REG_NUM-1:0] free_n;

  // Bitmap with this group's picks removed
  logic [PHY_REG_NUM-1:0] avail;
  logic                   got;

  // ==================================================
  // Lowest-first pick per valid slot
  // ==================================================
  always_comb begin
    avail      = free_q;
    alloc_ok_o = 1'b1;
    got        = 1'b0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      alloc_preg_o[i] = '0;
      got             = 1'b0;
      if (dest_valid_i[i]) begin
        // Scan upward, keep the first hit
        for (int p = 0; p < PHY_REG_NUM; p++) begin
          if (!got && avail[p]) begin
            alloc_preg_o[i] = PREG_W'(p);
            got             = 1'b1;
          end
        end
        // Hide the pick from later slots
        if (got) begin
          avail[alloc_preg_o[i]] = 1'b0;
        end else begin
          alloc_ok_o = 1'b0;
        end
      end
    end
  end

  // ==================================================
  // Bitmap update
  // ==================================================
  always_comb begin
    free_n = free_q;
    if (flush_en_i) begin
      // Free is whatever the committed map does not hold
      free_n = '1;
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        free_n[arch_map_i[r]] = 1'b0;
      end
    end else begin
      if (rename_en_i) begin
        free_n = avail;
      end
      // Returns from retiring entries
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (ret_valid_i[i]) begin
          free_n[ret_old_preg_i[i]] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Low registers back the identity map
      free_q <= {{(PHY_REG_NUM - ARCH_REG_NUM){1'b1}}, {ARCH_REG_NUM{1'b0}}};
    end else begin
      free_q <= free_n;
    end
  end

endmodule : free_list

// ==== design/rename_pkg.sv ====
package rename_pkg;

  // ==================================================
  // Architectural register file shape
  // ==================================================

  // Integer registers visible to software
  localparam int ARCH_REG_NUM = 32;

  // Index width for an architectural register
  localparam int AREG_W = $clog2(ARCH_REG_NUM);

  // ==================================================
  // Four-phase handshake controller
  // ==================================================

  // HS_IDLE  waiting for a request
  // HS_WORK  request taken, state updates on the next edge
  // HS_ACK   ack held until the request drops
  typedef enum logic [1:0] {
    HS_IDLE = 2'd0,
    HS_WORK = 2'd1,
    HS_ACK  = 2'd2
  } hs_state_e;

endpackage : rename_pkg

// ==== design/rename_top.sv ====
module rename_top #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  parameter int QUEUE_DEPTH  = 16,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic clk,
  input  logic rst_n,

  // Rename handshake
  input  logic                                           rename_req_i,
  input  logic [DECODE_WIDTH-1:0]                        dest_valid_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] dest_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] src0_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] src1_i,
  output logic                                           rename_ack_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            psrc0_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            psrc1_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            pdst_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0]            old_pdst_o,

  // Retire handshake
  input  logic                                retire_req_i,
  input  logic [$clog2(DECODE_WIDTH + 1)-1:0] retire_cnt_i,
  output logic                                retire_ack_o,

  // Flush handshake
  input  logic flush_req_i,
  output logic flush_ack_o
);

  import rename_pkg::*;

  // Grant bits
  localparam int GNT_REN = 0;
  localparam int GNT_RET = 1;
  localparam int GNT_FLS = 2;

  hs_state_e  state_q;
  hs_state_e  state_n;
  logic [2:0] gnt_q;
  logic [2:0] gnt_n;
  logic [2:0] req_vec;

  // One-cycle strobes
  logic rename_en;
  logic retire_en;
  logic flush_en;

  // Block interconnect
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            alloc_preg;
  logic                                           alloc_ok;
  logic                                           space_ok;
  logic [DECODE_WIDTH-1:0]                        ret_valid;
  logic [DECODE_WIDTH-1:0][AREG_W-1:0]            ret_dest;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            ret_preg;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            ret_old_preg;
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0]            arch_map;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            sr_psrc0;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            sr_psrc1;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            sr_pdst;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0]            sr_old_pdst;

  assign req_vec = {flush_req_i, retire_req_i, rename_req_i};

  // ==================================================
  // Handshake controller
  // ==================================================
  always_comb begin
    state_n = state_q;
    gnt_n   = gnt_q;
    case (state_q)
      HS_IDLE: begin
        // Retire over flush over rename
        if (retire_req_i) begin
          gnt_n   = 3'b010;
          state_n = HS_WORK;
        end else if (flush_req_i) begin
          gnt_n   = 3'b100;
          state_n = HS_WORK;
        end else if (rename_req_i && alloc_ok && space_ok) begin
          gnt_n   = 3'b001;
          state_n = HS_WORK;
        end
      end
      HS_WORK: state_n = HS_ACK;
      HS_ACK: begin
        // Hold until the granted req falls
        if (!(|(gnt_q & req_vec))) begin
          gnt_n   = '0;
          state_n = HS_IDLE;
        end
      end
      default: state_n = HS_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= HS_IDLE;
      gnt_q   <= '0;
    end else begin
      state_q <= state_n;
      gnt_q   <= gnt_n;
    end
  end

  assign rename_en = (state_q == HS_WORK) & gnt_q[GNT_REN];
  assign retire_en = (state_q == HS_WORK) & gnt_q[GNT_RET];
  assign flush_en  = (state_q == HS_WORK) & gnt_q[GNT_FLS];

  assign rename_ack_o = (state_q == HS_ACK) & gnt_q[GNT_REN];
  assign retire_ack_o = (state_q == HS_ACK) & gnt_q[GNT_RET];
  assign flush_ack_o  = (state_q == HS_ACK) & gnt_q[GNT_FLS];

  // Results held for the ack phase
  always_ff @(posedge clk) begin
    if (rename_en) begin
      psrc0_o    <= sr_psrc0;
      psrc1_o    <= sr_psrc1;
      pdst_o     <= sr_pdst;
      old_pdst_o <= sr_old_pdst;
    end
  end

  // ==================================================
  // Rename blocks
  // ==================================================
  spec_rat #(
    .PHY_REG_NUM (PHY_REG_NUM),
    .DECODE_WIDTH(DECODE_WIDTH)
  ) u_spec_rat (
    .clk         (clk),
    .rst_n       (rst_n),
    .rename_en_i (rename_en),
    .flush_en_i  (flush_en),
    .dest_valid_i(dest_valid_i),
    .dest_i      (dest_i),
    .src0_i      (src0_i),
    .src1_i      (src1_i),
    .alloc_preg_i(alloc_preg),
    .arch_map_i  (arch_map),
    .psrc0_o     (sr_psrc0),
    .psrc1_o     (sr_psrc1),
    .pdst_o      (sr_pdst),
    .old_pdst_o  (sr_old_pdst)
  );

  free_list #(
    .PHY_REG_NUM (PHY_REG_NUM),
    .DECODE_WIDTH(DECODE_WIDTH)
  ) u_free_list (
    .clk           (clk),
    .rst_n         (rst_n),
    .rename_en_i   (rename_en),
    .flush_en_i    (flush_en),
    .dest_valid_i  (dest_valid_i),
    .ret_valid_i   (ret_valid),
    .ret_old_preg_i(ret_old_preg),
    .arch_map_i    (arch_map),
    .alloc_preg_o  (alloc_preg),
    .alloc_ok_o    (alloc_ok)
  );

  arch_rat #(
    .PHY_REG_NUM (PHY_REG_NUM),
    .DECODE_WIDTH(DECODE_WIDTH)
  ) u_arch_rat (
    .clk        (clk),
    .rst_n      (rst_n),
    .ret_valid_i(ret_valid),
    .ret_dest_i (ret_dest),
    .ret_preg_i (ret_preg),
    .arch_map_o (arch_map)
  );

  commit_queue #(
    .PHY_REG_NUM (PHY_REG_NUM),
    .DECODE_WIDTH(DECODE_WIDTH),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_commit_queue (
    .clk           (clk),
    .rst_n         (rst_n),
    .rename_en_i   (rename_en),
    .retire_en_i   (retire_en),
    .flush_en_i    (flush_en),
    .retire_cnt_i  (retire_cnt_i),
    .dest_valid_i  (dest_valid_i),
    .dest_i        (dest_i),
    .pdst_i        (sr_pdst),
    .old_pdst_i    (sr_old_pdst),
    .space_ok_o    (space_ok),
    .ret_valid_o   (ret_valid),
    .ret_dest_o    (ret_dest),
    .ret_preg_o    (ret_preg),
    .ret_old_preg_o(ret_old_preg)
  );

endmodule : rename_top

// ==== design/spec_rat.sv ====
module spec_rat #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input  logic clk,
  input  logic rst_n,

  // Strobes from the top level controller
  input  logic rename_en_i,
  input  logic flush_en_i,

  // Decoded group, one entry per slot
  input  logic [DECODE_WIDTH-1:0]                        dest_valid_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] dest_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] src0_i,
  input  logic [DECODE_WIDTH-1:0][rename_pkg::AREG_W-1:0] src1_i,

  // New registers from the free list
  input  logic [DECODE_WIDTH-1:0][PREG_W-1:0] alloc_preg_i,

  // Committed map, copied in on flush
  input  logic [rename_pkg::ARCH_REG_NUM-1:0][PREG_W-1:0] arch_map_i,

  // Lookup results for the group
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0] pdst_o,
  output logic [DECODE_WIDTH-1:0][PREG_W-1:0] old_pdst_o
);

  import rename_pkg::*;

  // Speculative map, one physical index per architectural register
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] map_q;
  logic [ARCH_REG_NUM-1:0][PREG_W-1:0] map_n;

  // ==================================================
  // Lookup with in-group bypass
  // ==================================================
  always_comb begin
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      // Start from the stored map
      psrc0_o[i]    = map_q[src0_i[i]];
      psrc1_o[i]    = map_q[src1_i[i]];
      old_pdst_o[i] = map_q[dest_i[i]];
      // Earlier writers override, ascending so the youngest wins
      for (int j = 0; j < i; j++) begin
        if (dest_valid_i[j] && (dest_i[j] == src0_i[i])) begin
          psrc0_o[i] = alloc_preg_i[j];
        end
        if (dest_valid_i[j] && (dest_i[j] == src1_i[i])) begin
          psrc1_o[i] = alloc_preg_i[j];
        end
        if (dest_valid_i[j] && (dest_i[j] == dest_i[i])) begin
          old_pdst_o[i] = alloc_preg_i[j];
        end
      end
      // No destination, no old mapping to report
      if (!dest_valid_i[i]) begin
        old_pdst_o[i] = '0;
      end
      pdst_o[i] = alloc_preg_i[i];
    end
  end

  // ==================================================
  // Map update
  // ==================================================
  always_comb begin
    map_n = map_q;
    if (flush_en_i) begin
      // Drop all speculation
      map_n = arch_map_i;
    end else if (rename_en_i) begin
      // Later slot overwrites on WAW
      for (int i = 0; i < DECODE_WIDTH; i++) begin
        if (dest_valid_i[i]) begin
          map_n[dest_i[i]] = alloc_preg_i[i];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map, r -> p r
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        map_q[r] <= PREG_W'(r);
      end
    end else begin
      map_q <= map_n;
    end
  end

endmodule : spec_rat

// ==== files.f ====
design/rename_pkg.sv
design/spec_rat.sv
design/free_list.sv
design/arch_rat.sv
design/commit_queue.sv
design/rename_top.sv
verif/rename_assert.sv
verif/rename_tb.sv

// ==== verif/rename_assert.sv ====
module rename_assert #(
  parameter int PHY_REG_NUM  = 64,
  parameter int DECODE_WIDTH = 2,
  parameter int QUEUE_DEPTH  = 16,
  localparam int PREG_W      = $clog2(PHY_REG_NUM)
) (
  input logic clk,
  input logic rst_n,
  input logic rename_req_i,
  input logic retire_req_i,
  input logic flush_req_i,
  input logic rename_ack_i,
  input logic retire_ack_i,
  input logic flush_ack_i,
  input logic rename_en_i,
  input logic retire_en_i,
  input logic flush_en_i,
  input logic [$clog2(DECODE_WIDTH + 1)-1:0] retire_cnt_i,
  // psrc0, psrc1, pdst and old_pdst packed together
  input logic [4*DECODE_WIDTH*PREG_W-1:0] results_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // Queue occupancy seen from the strobes
  int unsigned occ;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occ <= 0;
    end else if (flush_en_i) begin
      occ <= 0;
    end else if (rename_en_i) begin
      occ <= occ + DECODE_WIDTH;
    end else if (retire_en_i) begin
      occ <= occ - retire_cnt_i;
    end
  end

  // ==================================================
  // Handshake rules
  // ==================================================
  ack_ren_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(rename_ack_i) |-> $past(rename_req_i))
    else $error("rename ack rose without a rename request");
  ack_ret_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(retire_ack_i) |-> $past(retire_req_i))
    else $error("retire ack rose without a retire request");
  ack_fls_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(flush_ack_i) |-> $past(flush_req_i))
    else $error("flush ack rose without a flush request");

  // One strobe per handshake
  strobe_1hot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({rename_en_i, retire_en_i, flush_en_i}))
    else $error("more than one update strobe active");

  // ==================================================
  // Queue bounds and result stability
  // ==================================================
  retire_bound: assert property (@(posedge clk) disable iff (!rst_n)
    retire_en_i |-> (retire_cnt_i <= occ))
    else $error("retire count above queue occupancy");
  occ_bound: assert property (@(posedge clk) disable iff (!rst_n)
    occ <= QUEUE_DEPTH)
    else $error("queue occupancy above depth");
  result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rename_ack_i |=> (!rename_ack_i || $stable(results_i)))
    else $error("rename results changed during ack");

endmodule : rename_assert

bind rename_top rename_assert #(
  .PHY_REG_NUM (PHY_REG_NUM),
  .DECODE_WIDTH(DECODE_WIDTH),
  .QUEUE_DEPTH (QUEUE_DEPTH)
) u_rename_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .rename_req_i(rename_req_i),
  .retire_req_i(retire_req_i),
  .flush_req_i (flush_req_i),
  .rename_ack_i(rename_ack_o),
  .retire_ack_i(retire_ack_o),
  .flush_ack_i (flush_ack_o),
  .rename_en_i (rename_en),
  .retire_en_i (retire_en),
  .flush_en_i  (flush_en),
  .retire_cnt_i(retire_cnt_i),
  .results_i   ({psrc0_o, psrc1_o, pdst_o, old_pdst_o})
);

// ==== verif/rename_tb.sv ====
module rename_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rename_pkg::*;

  localparam int PHY_REG_NUM  = 64;
  localparam int DECODE_WIDTH = 2;
  localparam int QUEUE_DEPTH  = 16;
  localparam int PREG_W       = $clog2(PHY_REG_NUM);
  localparam int RCNT_W       = $clog2(DECODE_WIDTH + 1);

  // Request selectors
  localparam int REQ_RENAME = 0;
  localparam int REQ_RETIRE = 1;
  localparam int REQ_FLUSH  = 2;

  // Test lengths in requests, drains included
  localparam int TOTAL_REQS = 1 + 600 + 20 + 20 + 16;
  localparam int MAX_CYCLES = 8 * TOTAL_REQS * 6;

  logic clk;
  logic rst_n;
  logic rename_req;
  logic retire_req;
  logic flush_req;
  logic [RCNT_W-1:0] retire_cnt;
  logic rename_ack;
  logic retire_ack;
  logic flush_ack;
  logic [DECODE_WIDTH-1:0]             dest_valid;
  logic [DECODE_WIDTH-1:0][AREG_W-1:0] dest;
  logic [DECODE_WIDTH-1:0][AREG_W-1:0] src0;
  logic [DECODE_WIDTH-1:0][AREG_W-1:0] src1;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc0;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] psrc1;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] pdst;
  logic [DECODE_WIDTH-1:0][PREG_W-1:0] old_pdst;

  // Reference model state
  int spec_map [ARCH_REG_NUM];
  int arch_map [ARCH_REG_NUM];
  bit free_bits [PHY_REG_NUM];
  int cq_valid [$];
  int cq_dest [$];
  int cq_preg [$];
  int cq_old [$];
  int exp_psrc0 [DECODE_WIDTH];
  int exp_psrc1 [DECODE_WIDTH];
  int exp_pdst [DECODE_WIDTH];
  int exp_old [DECODE_WIDTH];

  // Bookkeeping
  int seed;
  int cycles;
  string test_name;
  int test_checks;
  int test_errors;
  int tests_run;
  int failed_tests;
  int total_errors;

  rename_top #(
    .PHY_REG_NUM (PHY_REG_NUM),
    .DECODE_WIDTH(DECODE_WIDTH),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .rename_req_i(rename_req),
    .dest_valid_i(dest_valid),
    .dest_i      (dest),
    .src0_i      (src0),
    .src1_i      (src1),
    .rename_ack_o(rename_ack),
    .psrc0_o     (psrc0),
    .psrc1_o     (psrc1),
    .pdst_o      (pdst),
    .old_pdst_o  (old_pdst),
    .retire_req_i(retire_req),
    .retire_cnt_i(retire_cnt),
    .retire_ack_o(retire_ack),
    .flush_req_i (flush_req),
    .flush_ack_o (flush_ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Run limit
  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: no progress within %0d cycles", MAX_CYCLES);
    $display("** FAIL **");
    $finish;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic int lowest_free();
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      if (free_bits[p]) begin
        return p;
      end
    end
    return -1;
  endfunction

  function automatic int free_count();
    int n;
    n = 0;
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      n += free_bits[p];
    end
    return n;
  endfunction

  // Lowest register that no committed mapping points at
  function automatic int lowest_unmapped();
    bit used;
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      used = 1'b0;
      for (int r = 0; r < ARCH_REG_NUM; r++) begin
        if (arch_map[r] == p) begin
          used = 1'b1;
        end
      end
      if (!used) begin
        return p;
      end
    end
    return -1;
  endfunction

  function automatic bit rename_fits();
    int need;
    need = 0;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      need += dest_valid[i];
    end
    return (free_count() >= need) && (cq_valid.size() <= QUEUE_DEPTH - DECODE_WIDTH);
  endfunction

  // Slots in order, each sees the writes of the slots before it
  task automatic model_rename();
    int p;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      exp_psrc0[i] = spec_map[src0[i]];
      exp_psrc1[i] = spec_map[src1[i]];
      exp_pdst[i]  = 0;
      exp_old[i]   = 0;
      if (dest_valid[i]) begin
        p = lowest_free();
        free_bits[p] = 1'b0;
        exp_pdst[i] = p;
        exp_old[i]  = spec_map[dest[i]];
        spec_map[dest[i]] = p;
      end
      cq_valid.push_back(dest_valid[i]);
      cq_dest.push_back(dest[i]);
      cq_preg.push_back(exp_pdst[i]);
      cq_old.push_back(exp_old[i]);
    end
  endtask

  // In-order commit, so the later writer of a register wins
  task automatic model_retire(input int cnt);
    int v;
    int d;
    int p;
    int o;
    for (int k = 0; k < cnt; k++) begin
      v = cq_valid.pop_front();
      d = cq_dest.pop_front();
      p = cq_preg.pop_front();
      o = cq_old.pop_front();
      if (v != 0) begin
        arch_map[d] = p;
        free_bits[o] = 1'b1;
      end
    end
  endtask

  task automatic model_flush();
    spec_map = arch_map;
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      free_bits[p] = 1'b1;
    end
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      free_bits[arch_map[r]] = 1'b0;
    end
    cq_valid.delete();
    cq_dest.delete();
    cq_preg.delete();
    cq_old.delete();
  endtask

  // ==================================================
  // Handshake drivers
  // ==================================================
  function automatic logic ack_of(input int which);
    case (which)
      REQ_RENAME: return rename_ack;
      REQ_RETIRE: return retire_ack;
      default:    return flush_ack;
    endcase
  endfunction

  task automatic set_req(input int which, input logic level);
    case (which)
      REQ_RENAME: rename_req = level;
      REQ_RETIRE: retire_req = level;
      default:    flush_req  = level;
    endcase
  endtask

  // Returns 1 ns after the edge, where inputs are driven
  task automatic await_ack(input int which, input logic level);
    do begin
      @(posedge clk);
      #1;
    end while (ack_of(which) !== level);
  endtask

  task automatic check_val(input string what, input int expected, input int actual);
    test_checks++;
    assert (expected == actual) else begin
      $display("MISMATCH %s %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic rename_group();
    int hold;
    model_rename();
    set_req(REQ_RENAME, 1'b1);
    await_ack(REQ_RENAME, 1'b1);
    // Keep req up a few cycles, ack and results stay put
    hold = $unsigned($random(seed)) % 3;
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    test_checks++;
    assert (rename_ack) else begin
      $display("rename ack dropped while the request was still high");
      test_errors++;
    end
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      check_val($sformatf("psrc0[%0d]", i), exp_psrc0[i], psrc0[i]);
      check_val($sformatf("psrc1[%0d]", i), exp_psrc1[i], psrc1[i]);
      check_val($sformatf("pdst[%0d]", i), exp_pdst[i], pdst[i]);
      check_val($sformatf("old_pdst[%0d]", i), exp_old[i], old_pdst[i]);
    end
    set_req(REQ_RENAME, 1'b0);
    await_ack(REQ_RENAME, 1'b0);
  endtask

  task automatic retire_entries(input int cnt);
    retire_cnt = RCNT_W'(cnt);
    model_retire(cnt);
    set_req(REQ_RETIRE, 1'b1);
    await_ack(REQ_RETIRE, 1'b1);
    set_req(REQ_RETIRE, 1'b0);
    await_ack(REQ_RETIRE, 1'b0);
  endtask

  task automatic flush_all();
    model_flush();
    set_req(REQ_FLUSH, 1'b1);
    await_ack(REQ_FLUSH, 1'b1);
    set_req(REQ_FLUSH, 1'b0);
    await_ack(REQ_FLUSH, 1'b0);
  endtask

  function automatic int retire_max();
    return (cq_valid.size() < DECODE_WIDTH) ? cq_valid.size() : DECODE_WIDTH;
  endfunction

  // Retire until the current group fits
  task automatic make_room();
    while (!rename_fits()) begin
      retire_entries(retire_max());
    end
  endtask

  task automatic drain_queue();
    while (cq_valid.size() > 0) begin
      retire_entries(retire_max());
    end
  endtask

  // ==================================================
  // Stimulus
  // ==================================================
  function automatic logic [AREG_W-1:0] pick_reg(input bit narrow);
    if (narrow) begin
      return AREG_W'($unsigned($random(seed)) % 4);
    end
    return AREG_W'($unsigned($random(seed)) % ARCH_REG_NUM);
  endfunction

  task automatic set_group(input logic [DECODE_WIDTH-1:0] dv, input int d0, input int d1,
                           input int a0, input int a1, input int b0, input int b1);
    dest_valid = dv;
    dest[0] = AREG_W'(d0);
    dest[1] = AREG_W'(d1);
    src0[0] = AREG_W'(a0);
    src0[1] = AREG_W'(a1);
    src1[0] = AREG_W'(b0);
    src1[1] = AREG_W'(b1);
  endtask

  // Modes: 0 wide, 1 narrow, 2 WAW, 3 slot 1 reads slot 0
  task automatic random_group();
    int mode;
    mode = $unsigned($random(seed)) % 4;
    dest_valid = (($random(seed) & 7) == 0) ? 2'($random(seed)) : 2'b11;
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      dest[i] = pick_reg(mode == 1);
      src0[i] = pick_reg(mode == 1);
      src1[i] = pick_reg(mode == 1);
    end
    if (mode == 2) begin
      dest[1] = dest[0];
    end
    if (mode == 3) begin
      src0[1] = dest[0];
      src1[1] = dest[0];
    end
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) begin
      failed_tests++;
    end
    $display("test %-14s %0d checks, %0d errors", test_name, test_checks, test_errors);
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin
    int first_free;
    seed = 40;
    tests_run = 0;
    failed_tests = 0;
    total_errors = 0;
    rst_n = 1'b0;
    rename_req = 1'b0;
    retire_req = 1'b0;
    flush_req = 1'b0;
    retire_cnt = '0;
    dest_valid = '0;
    dest = '0;
    src0 = '0;
    src1 = '0;
    // Model reset state, identity maps
    for (int r = 0; r < ARCH_REG_NUM; r++) begin
      spec_map[r] = r;
      arch_map[r] = r;
    end
    for (int p = 0; p < PHY_REG_NUM; p++) begin
      free_bits[p] = (p >= ARCH_REG_NUM);
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // First group after reset
    begin_test("reset_rename");
    set_group(2'b11, 5, 6, 3, 1, 4, 2);
    rename_group();
    check_val("pdst0 lit", 32, pdst[0]);
    check_val("pdst1 lit", 33, pdst[1]);
    check_val("psrc0 lit", 3, psrc0[0]);
    check_val("old1 lit", 6, old_pdst[1]);
    end_test();

    // Random groups with random retires
    begin_test("random_groups");
    for (int g = 0; g < 200; g++) begin
      random_group();
      make_room();
      rename_group();
      if ($random(seed) & 1) begin
        retire_entries($unsigned($random(seed)) % (retire_max() + 1));
      end
    end
    end_test();

    // Fill the queue, then expect the rename to wait
    begin_test("backpressure");
    drain_queue();
    random_group();
    while (rename_fits()) begin
      rename_group();
      random_group();
    end
    set_req(REQ_RENAME, 1'b1);
    repeat (12) begin
      @(posedge clk);
      #1;
      test_checks++;
      assert (!rename_ack) else begin
        $display("rename was acknowledged while the queue or free list was full");
        test_errors++;
      end
    end
    set_req(REQ_RENAME, 1'b0);
    @(posedge clk);
    #1;
    retire_entries(DECODE_WIDTH);
    first_free = lowest_free();
    rename_group();
    if (dest_valid[0]) begin
      check_val("lowest freed", first_free, pdst[0]);
    end
    end_test();

    // Same-register writes retire, then a flush exposes the committed map
    begin_test("retire_flush");
    drain_queue();
    set_group(2'b11, 7, 7, 1, 7, 2, 3);
    rename_group();
    set_group(2'b11, 9, 9, 9, 9, 4, 5);
    rename_group();
    retire_entries(2);
    retire_entries(2);
    set_group(2'b11, 7, 9, 7, 9, 7, 9);
    rename_group();
    flush_all();
    set_group(2'b00, 0, 0, 7, 9, 9, 7);
    rename_group();
    check_val("arch r7", arch_map[7], psrc0[0]);
    check_val("arch r9", arch_map[9], psrc0[1]);
    end_test();

    // Allocation after a flush restarts from the rebuilt free set
    begin_test("flush_alloc");
    for (int g = 0; g < 3; g++) begin
      random_group();
      make_room();
      rename_group();
    end
    retire_entries(retire_max());
    flush_all();
    first_free = lowest_unmapped();
    set_group(2'b11, 1, 2, 3, 4, 5, 6);
    rename_group();
    check_val("first alloc", first_free, pdst[0]);
    end_test();

    $display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, total_errors);
    if (total_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule : rename_tb
